// File: Makefile
TOP := tb_cpu_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

// File: filelist.f
src/cpu_pkg.sv
src/regfile.sv
src/pipe_reg.sv
src/hilo_unit.sv
src/instr_fetch.sv
src/decode_and_issue.sv
src/instr_exec.sv
src/cpu_core.sv
sim/tb_cpu_core.sv

// File: sim/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*; ();

localparam virt_t       RESET_PC  = 32'h0000_1000;
localparam int unsigned MEM_WORDS = 64;
localparam int          TIMEOUT   = 2000;
localparam int          DRAIN     = 20;

logic        clk = 1'b0;
logic        rst_n = 1'b0;
logic        bus_stall = 1'b0;
uint64_t     bus_rddata;
uint32_t     offset;
uint32_t     word_idx;
uint32_t     next_idx;
ibus_req_t   ibus_req;
ibus_resp_t  ibus_resp;
cpu_commit_t [ISSUE_NUM-1:0] commit;

logic [31:0] mem [MEM_WORDS];
logic [31:0] prog[$];
cpu_commit_t expected[$];
int unsigned stall_rate = 0;
string       test_name;
int          error_count = 0;
int          test_count = 0;
int          failed_tests = 0;
bit          dual_seen;

always #5 clk = ~clk;

cpu_core #(
	.RESET_PC         ( RESET_PC ),
	.INSTR_FIFO_DEPTH ( 8        )
) i_cpu_core (
	.clk,
	.rst_n,
	.ibus_req,
	.ibus_resp,
	.commit
);

// instruction memory with nops outside the loaded window
always_comb begin
	offset     = ibus_req.address - RESET_PC;
	word_idx   = {2'b0, offset[31:2]};
	next_idx   = word_idx + 32'd1;
	bus_rddata = '0;
	if (word_idx < MEM_WORDS)
		bus_rddata[31:0] = mem[word_idx[5:0]];
	if (next_idx < MEM_WORDS)
		bus_rddata[63:32] = mem[next_idx[5:0]];
end

assign ibus_resp = '{rddata: bus_rddata, stall: bus_stall};

always @(posedge clk) begin
	if (stall_rate > 0)
		bus_stall <= ($urandom % 100) < stall_rate;
	else
		bus_stall <= 1'b0;
end

function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
	return {OPC_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] itype_word(input logic [5:0] opc, input logic [4:0] rt,
	input logic [4:0] rs, input logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

// in-order reference model with one expected commit per retiring instruction
task automatic build_expected();
	logic [31:0] gpr [32];
	logic [63:0] hilo_val;
	logic [31:0] w;
	logic [31:0] val;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  dst;
	bit          retires;
	cpu_commit_t entry;
	for (int r = 0; r < 32; r++)
		gpr[r] = '0;
	hilo_val = '0;
	expected.delete();
	for (int k = 0; k < prog.size(); k++) begin
		w       = prog[k];
		rs      = w[25:21];
		rt      = w[20:16];
		dst     = w[15:11];
		val     = '0;
		retires = 1'b1;
		if (w == '0) begin
			retires = 1'b0;
		end else if (w[31:26] == OPC_SPECIAL) begin
			case (w[5:0])
				FN_SLL:  val = gpr[rt] << w[10:6];
				FN_ADDU: val = gpr[rs] + gpr[rt];
				FN_SUBU: val = gpr[rs] - gpr[rt];
				FN_AND:  val = gpr[rs] & gpr[rt];
				FN_OR:   val = gpr[rs] | gpr[rt];
				FN_XOR:  val = gpr[rs] ^ gpr[rt];
				FN_NOR:  val = ~(gpr[rs] | gpr[rt]);
				FN_SLTU: val = (gpr[rs] < gpr[rt]) ? 32'd1 : 32'd0;
				FN_MFHI: val = hilo_val[63:32];
				FN_MFLO: val = hilo_val[31:0];
				FN_MULTU: begin
					hilo_val = {32'b0, gpr[rs]} * {32'b0, gpr[rt]};
					dst      = '0;
				end
				default: retires = 1'b0;
			endcase
		end else if (w[31:26] == OPC_ADDIU) begin
			dst = rt;
			val = gpr[rs] + {{16{w[15]}}, w[15:0]};
		end else if (w[31:26] == OPC_ORI) begin
			dst = rt;
			val = gpr[rs] | {16'b0, w[15:0]};
		end else if (w[31:26] == OPC_LUI) begin
			dst = rt;
			val = {w[15:0], 16'b0};
		end else begin
			retires = 1'b0;
		end
		if (retires) begin
			entry.valid = 1'b1;
			entry.pc    = RESET_PC + 32'(4 * k);
			entry.rd    = dst;
			entry.wdata = val;
			expected.push_back(entry);
			if (dst != '0)
				gpr[dst] = val;
		end
	end
endtask

// compare this cycle's commits with slot 0 first
task automatic check_commits();
	cpu_commit_t exp_c;
	string       exp_s;
	string       act_s;
	if (commit[0].valid && commit[1].valid)
		dual_seen = 1'b1;
	for (int i = 0; i < ISSUE_NUM; i++) begin
		if (commit[i].valid) begin
			assert (expected.size() > 0) else begin
				error_count++;
				$display("%s: unexpected commit at pc %h with nothing left to retire",
					test_name, commit[i].pc);
			end
			if (expected.size() > 0) begin
				exp_c = expected.pop_front();
				assert (commit[i] == exp_c) else begin
					error_count++;
					exp_s = $sformatf("pc %h rd %0d wdata %h",
						exp_c.pc, exp_c.rd, exp_c.wdata);
					act_s = $sformatf("pc %h rd %0d wdata %h",
						commit[i].pc, commit[i].rd, commit[i].wdata);
					$display("mismatch in %s: expected %s, actual %s",
						test_name, exp_s, act_s);
				end
			end
		end
	end
endtask

task automatic run_program(input string name, input bit need_dual);
	int errs_before;
	int waited;
	bit got_read;
	errs_before = error_count;
	test_name   = name;
	dual_seen   = 1'b0;
	for (int i = 0; i < MEM_WORDS; i++)
		mem[i] = (i < prog.size()) ? prog[i] : '0;
	build_expected();
	@(posedge clk);
	rst_n <= 1'b0;
	repeat (9) @(posedge clk);
	@(negedge clk);
	assert (!commit[0].valid && !commit[1].valid && !ibus_req.read) else begin
		error_count++;
		$display("%s: commit or fetch active while in reset", name);
	end
	@(posedge clk);
	rst_n <= 1'b1;

	waited   = 0;
	got_read = 1'b0;
	while (!got_read && waited < TIMEOUT) begin
		@(negedge clk);
		check_commits();
		got_read = ibus_req.read;
		waited++;
	end
	assert (got_read) else begin
		error_count++;
		$display("%s: no instruction read after reset", name);
	end
	assert (ibus_req.address == RESET_PC) else begin
		error_count++;
		$display("mismatch in %s: expected first fetch %h, actual %h",
			name, RESET_PC, ibus_req.address);
	end

	waited = 0;
	while (expected.size() > 0 && waited < TIMEOUT) begin
		@(negedge clk);
		check_commits();
		waited++;
	end
	assert (expected.size() == 0) else begin
		error_count++;
		$display("%s: timed out with %0d instructions not committed", name, expected.size());
	end
	// stray commits after the last expected one
	repeat (DRAIN) begin
		@(negedge clk);
		check_commits();
	end
	if (need_dual) begin
		assert (dual_seen) else begin
			error_count++;
			$display("%s: no cycle committed both slots", name);
		end
	end

	test_count++;
	if (error_count == errs_before) begin
		$display("%s: ok", name);
	end else begin
		failed_tests++;
		$display("%s: %0d errors", name, error_count - errs_before);
	end
endtask

task automatic load_alu_program();
	prog.delete();
	prog.push_back(itype_word(OPC_ADDIU, 5'd1, 5'd0, 16'h1234));
	prog.push_back(itype_word(OPC_ORI, 5'd2, 5'd0, 16'hf0f0));
	prog.push_back(itype_word(OPC_LUI, 5'd3, 5'd0, 16'hdead));
	prog.push_back(itype_word(OPC_ADDIU, 5'd4, 5'd0, 16'hfffb));
	prog.push_back(rtype_word(FN_AND, 5'd5, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_OR, 5'd6, 5'd1, 5'd3, 5'd0));
	prog.push_back(rtype_word(FN_XOR, 5'd7, 5'd2, 5'd4, 5'd0));
	prog.push_back(rtype_word(FN_NOR, 5'd8, 5'd1, 5'd4, 5'd0));
	// a jump is outside the subset
	prog.push_back(32'h0800_0010);
	prog.push_back(rtype_word(FN_SLTU, 5'd9, 5'd1, 5'd4, 5'd0));
	prog.push_back(rtype_word(FN_SLTU, 5'd10, 5'd4, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SLL, 5'd11, 5'd0, 5'd1, 5'd4));
	prog.push_back(rtype_word(FN_SLL, 5'd12, 5'd0, 5'd4, 5'd31));
	prog.push_back(itype_word(OPC_ORI, 5'd13, 5'd3, 16'h00ff));
endtask

task automatic test_reset_state();
	prog.delete();
	prog.push_back(itype_word(OPC_ADDIU, 5'd1, 5'd0, 16'h0001));
	prog.push_back(itype_word(OPC_ADDIU, 5'd2, 5'd0, 16'h0002));
	run_program("reset_state", 1'b0);
endtask

task automatic test_independent_alu();
	stall_rate = 0;
	load_alu_program();
	run_program("independent_alu", 1'b1);
endtask

task automatic test_dependent_chain();
	prog.delete();
	prog.push_back(itype_word(OPC_ADDIU, 5'd1, 5'd0, 16'd100));
	prog.push_back(rtype_word(FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd3, 5'd2, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd4, 5'd3, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd1, 5'd1, 5'd4, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd2, 5'd1, 5'd4, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd5, 5'd2, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd6, 5'd5, 5'd5, 5'd0));
	// producers two apart reach the consumer from writeback
	prog.push_back(itype_word(OPC_ADDIU, 5'd8, 5'd0, 16'd7));
	prog.push_back(itype_word(OPC_ADDIU, 5'd9, 5'd0, 16'd9));
	prog.push_back(rtype_word(FN_ADDU, 5'd10, 5'd8, 5'd9, 5'd0));
	prog.push_back(rtype_word(FN_SUBU, 5'd11, 5'd10, 5'd6, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd12, 5'd11, 5'd8, 5'd0));
	run_program("dependent_chain", 1'b0);
endtask

task automatic test_multu_hilo();
	prog.delete();
	prog.push_back(itype_word(OPC_LUI, 5'd1, 5'd0, 16'h8000));
	prog.push_back(itype_word(OPC_ORI, 5'd1, 5'd1, 16'h0003));
	prog.push_back(itype_word(OPC_LUI, 5'd2, 5'd0, 16'hffff));
	prog.push_back(itype_word(OPC_ORI, 5'd2, 5'd2, 16'hfff0));
	prog.push_back(rtype_word(FN_MULTU, 5'd0, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_MFHI, 5'd3, 5'd0, 5'd0, 5'd0));
	prog.push_back(rtype_word(FN_MFLO, 5'd4, 5'd0, 5'd0, 5'd0));
	prog.push_back(rtype_word(FN_MULTU, 5'd0, 5'd3, 5'd4, 5'd0));
	prog.push_back(rtype_word(FN_MFHI, 5'd5, 5'd0, 5'd0, 5'd0));
	prog.push_back(rtype_word(FN_MFLO, 5'd6, 5'd0, 5'd0, 5'd0));
	prog.push_back(rtype_word(FN_MULTU, 5'd0, 5'd1, 5'd1, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd7, 5'd1, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_MFLO, 5'd8, 5'd0, 5'd0, 5'd0));
	prog.push_back(rtype_word(FN_MFHI, 5'd9, 5'd0, 5'd0, 5'd0));
	run_program("multu_hilo", 1'b0);
endtask

task automatic test_zero_register();
	prog.delete();
	prog.push_back(itype_word(OPC_ADDIU, 5'd0, 5'd0, 16'h0055));
	prog.push_back(itype_word(OPC_LUI, 5'd0, 5'd0, 16'h1234));
	prog.push_back(rtype_word(FN_ADDU, 5'd1, 5'd0, 5'd0, 5'd0));
	prog.push_back(itype_word(OPC_ORI, 5'd2, 5'd0, 16'h0007));
	prog.push_back(rtype_word(FN_OR, 5'd0, 5'd2, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_ADDU, 5'd3, 5'd0, 5'd2, 5'd0));
	prog.push_back(rtype_word(FN_SLL, 5'd4, 5'd0, 5'd0, 5'd3));
	prog.push_back(rtype_word(FN_NOR, 5'd5, 5'd0, 5'd0, 5'd0));
	run_program("zero_register", 1'b0);
endtask

task automatic test_alu_with_stall();
	stall_rate = 40;
	load_alu_program();
	run_program("alu_with_bus_stall", 1'b0);
	stall_rate = 0;
endtask

initial begin
	void'($urandom(32'hcf27));
	for (int i = 0; i < MEM_WORDS; i++)
		mem[i] = '0;
	test_reset_state();
	test_independent_alu();
	test_dependent_chain();
	test_multu_hilo();
	test_zero_register();
	test_alu_with_stall();
	$display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
	if (error_count == 0) begin
		$display("sim passed");
	end else begin
		$display("sim failed");
	end
	$finish;
end

endmodule

// File: src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
	parameter virt_t RESET_PC         = 32'hbfc0_0000,
	parameter int    INSTR_FIFO_DEPTH = 8
) (
	input  logic                         clk,
	input  logic                         rst_n,
	output ibus_req_t                    ibus_req,
	input  ibus_resp_t                   ibus_resp,
	output cpu_commit_t [ISSUE_NUM-1:0]  commit
);

typedef pipeline_decode_t [ISSUE_NUM-1:0] decode_slots_t;
typedef pipeline_exec_t   [ISSUE_NUM-1:0] exec_slots_t;

fetch_entry_t [1:0]           fetch_entry;
logic [1:0]                   issue_num;
reg_addr_t [3:0]              reg_raddr;
uint32_t [3:0]                reg_rdata;
logic [ISSUE_NUM-1:0]         reg_we;
reg_addr_t [ISSUE_NUM-1:0]    reg_waddr;
uint32_t [ISSUE_NUM-1:0]      reg_wdata;
decode_slots_t                pipeline_decode, pipeline_decode_d;
exec_slots_t                  pipeline_exec, pipeline_wb;
hilo_req_t                    hilo_req;
uint64_t                      hilo;
logic [ISSUE_NUM-1:0]         stall_req_ex;
logic                         stall_ex;

assign stall_ex = |stall_req_ex;

instr_fetch #(
	.RESET_PC         ( RESET_PC         ),
	.INSTR_FIFO_DEPTH ( INSTR_FIFO_DEPTH )
) instr_fetch_inst (
	.clk,
	.rst_n,
	.ibus_req,
	.ibus_resp,
	.issue_num,
	.fetch_entry
);

decode_and_issue decode_issue_inst (
	.fetch_entry,
	.stall_ex,
	.pipeline_exec,
	.pipeline_wb,
	.reg_raddr,
	.reg_rdata,
	.pipeline_decode,
	.issue_num
);

regfile #(
	.REG_NUM     ( REG_NUM   ),
	.DATA_WIDTH  ( 32        ),
	.WRITE_PORTS ( ISSUE_NUM ),
	.READ_PORTS  ( 4         ),
	.ZERO_KEEP   ( 1'b1      )
) regfile_inst (
	.clk,
	.rst_n,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

hilo_unit hilo_inst (
	.clk,
	.rst_n,
	.wb_req ( hilo_req ),
	.hilo
);

// ID/EX holds while a multu occupies EX
pipe_reg #(.T(decode_slots_t)) id_ex_reg (
	.clk,
	.rst_n,
	.stall      ( stall_ex          ),
	.stall_next ( stall_ex          ),
	.d          ( pipeline_decode   ),
	.q          ( pipeline_decode_d )
);

for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_exec
	instr_exec exec_inst (
		.clk,
		.rst_n,
		.data      ( pipeline_decode_d[i] ),
		.hilo      ( hilo                 ),
		.result    ( pipeline_exec[i]     ),
		.stall_req ( stall_req_ex[i]      )
	);
end

pipe_reg #(.T(exec_slots_t)) ex_wb_reg (
	.clk,
	.rst_n,
	.stall      ( stall_ex      ),
	.stall_next ( 1'b0          ),
	.d          ( pipeline_exec ),
	.q          ( pipeline_wb   )
);

for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_write_back
	assign reg_we[i]       = pipeline_wb[i].valid;
	assign reg_waddr[i]    = pipeline_wb[i].rd;
	assign reg_wdata[i]    = pipeline_wb[i].wdata;
	assign commit[i].valid = pipeline_wb[i].valid;
	assign commit[i].pc    = pipeline_wb[i].pc;
	assign commit[i].rd    = pipeline_wb[i].rd;
	assign commit[i].wdata = pipeline_wb[i].wdata;
end

// slot 1 is younger, so its HI/LO write wins
always_comb begin
	hilo_req = '0;
	for (int i = 0; i < ISSUE_NUM; i++) begin
		if (pipeline_wb[i].hiloreq.we)
			hilo_req = pipeline_wb[i].hiloreq;
	end
end

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

	localparam int ISSUE_NUM = 2;
	localparam int REG_NUM   = 32;

	typedef logic [31:0] uint32_t;
	typedef logic [63:0] uint64_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] virt_t;

	// primary opcodes
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_ADDIU   = 6'h09;
	localparam logic [5:0] OPC_ORI     = 6'h0d;
	localparam logic [5:0] OPC_LUI     = 6'h0f;

	// SPECIAL function codes
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_NOR   = 6'h27;
	localparam logic [5:0] FN_SLTU  = 6'h2b;

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADDU,
		OP_SUBU,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLTU,
		OP_SLL,
		OP_LUI,
		OP_MULTU,
		OP_MFHI,
		OP_MFLO
	} alu_op_t;

	typedef struct packed {
		logic    we;
		uint64_t wdata;
	} hilo_req_t;

	typedef struct packed {
		logic  read;
		virt_t address;
	} ibus_req_t;

	// lower word of rddata is the instruction at the lower address
	typedef struct packed {
		uint64_t rddata;
		logic    stall;
	} ibus_resp_t;

	typedef struct packed {
		logic    valid;
		virt_t   pc;
		uint32_t instr;
	} fetch_entry_t;

	typedef struct packed {
		logic      valid;
		virt_t     pc;
		alu_op_t   op;
		reg_addr_t rd;
		uint32_t   op_a;
		uint32_t   op_b;
		logic [4:0] shamt;
	} pipeline_decode_t;

	typedef struct packed {
		logic      valid;
		virt_t     pc;
		reg_addr_t rd;
		uint32_t   wdata;
		hilo_req_t hiloreq;
	} pipeline_exec_t;

	typedef struct packed {
		logic      valid;
		virt_t     pc;
		reg_addr_t rd;
		uint32_t   wdata;
	} cpu_commit_t;

endpackage

// File: src/decode_and_issue.sv
`timescale 1ns/1ps

module decode_and_issue import cpu_pkg::*; (
	input  fetch_entry_t     [1:0] fetch_entry,
	input  logic                   stall_ex,
	input  pipeline_exec_t   [1:0] pipeline_exec,
	input  pipeline_exec_t   [1:0] pipeline_wb,
	output reg_addr_t        [3:0] reg_raddr,
	input  uint32_t          [3:0] reg_rdata,
	output pipeline_decode_t [1:0] pipeline_decode,
	output logic             [1:0] issue_num
);

alu_op_t   [1:0] op;
reg_addr_t [1:0] dest;
uint32_t   [1:0] imm;
logic      [1:0] use_imm;
logic      [1:0] is_multu;
logic      [1:0] uses_hilo;
logic            raw_dep;
logic            hilo_clash;

// the newest producer wins, EX slot 1 first and the regfile last
function automatic uint32_t forward(
	input reg_addr_t             addr,
	input uint32_t               rf_val,
	input pipeline_exec_t  [1:0] ex,
	input pipeline_exec_t  [1:0] wb
);
	uint32_t val;
	val = rf_val;
	for (int i = 0; i < 2; i++) begin
		if (wb[i].valid && wb[i].rd == addr)
			val = wb[i].wdata;
	end
	for (int i = 0; i < 2; i++) begin
		if (ex[i].valid && ex[i].rd == addr)
			val = ex[i].wdata;
	end
	if (addr == '0)
		val = '0;
	return val;
endfunction

always_comb begin
	for (int i = 0; i < 2; i++) begin
		op[i]      = OP_NOP;
		dest[i]    = '0;
		use_imm[i] = 1'b0;
		imm[i]     = {16'b0, fetch_entry[i].instr[15:0]};
		case (fetch_entry[i].instr[31:26])
			OPC_SPECIAL: begin
				dest[i] = fetch_entry[i].instr[15:11];
				case (fetch_entry[i].instr[5:0])
					FN_SLL:  op[i] = OP_SLL;
					FN_ADDU: op[i] = OP_ADDU;
					FN_SUBU: op[i] = OP_SUBU;
					FN_AND:  op[i] = OP_AND;
					FN_OR:   op[i] = OP_OR;
					FN_XOR:  op[i] = OP_XOR;
					FN_NOR:  op[i] = OP_NOR;
					FN_SLTU: op[i] = OP_SLTU;
					FN_MFHI: op[i] = OP_MFHI;
					FN_MFLO: op[i] = OP_MFLO;
					FN_MULTU: begin
						op[i]   = OP_MULTU;
						dest[i] = '0;
					end
					default: dest[i] = '0;
				endcase
			end
			OPC_ADDIU: begin
				op[i]      = OP_ADDU;
				dest[i]    = fetch_entry[i].instr[20:16];
				use_imm[i] = 1'b1;
				imm[i]     = {{16{fetch_entry[i].instr[15]}}, fetch_entry[i].instr[15:0]};
			end
			OPC_ORI: begin
				op[i]      = OP_OR;
				dest[i]    = fetch_entry[i].instr[20:16];
				use_imm[i] = 1'b1;
			end
			OPC_LUI: begin
				op[i]      = OP_LUI;
				dest[i]    = fetch_entry[i].instr[20:16];
				use_imm[i] = 1'b1;
			end
			default: ;
		endcase
		// all-zero word is the canonical nop, not an sll
		if (fetch_entry[i].instr == '0) begin
			op[i]   = OP_NOP;
			dest[i] = '0;
		end
		is_multu[i]  = op[i] == OP_MULTU;
		uses_hilo[i] = op[i] == OP_MULTU || op[i] == OP_MFHI || op[i] == OP_MFLO;
	end
end

// any rs or rt match with slot 0's destination splits the pair
assign raw_dep = dest[0] != '0 && (fetch_entry[1].instr[25:21] == dest[0] ||
	fetch_entry[1].instr[20:16] == dest[0]);
assign hilo_clash = (is_multu[0] && uses_hilo[1]) || (is_multu[1] && uses_hilo[0]);

always_comb begin
	if (stall_ex || ~fetch_entry[0].valid)
		issue_num = 2'd0;
	else if (~fetch_entry[1].valid || raw_dep || hilo_clash)
		issue_num = 2'd1;
	else
		issue_num = 2'd2;
end

always_comb begin
	for (int i = 0; i < 2; i++) begin
		reg_raddr[2*i]   = fetch_entry[i].instr[25:21];
		reg_raddr[2*i+1] = fetch_entry[i].instr[20:16];
		pipeline_decode[i].valid = fetch_entry[i].valid && op[i] != OP_NOP &&
			2'(i) < issue_num;
		pipeline_decode[i].pc    = fetch_entry[i].pc;
		pipeline_decode[i].op    = op[i];
		pipeline_decode[i].rd    = dest[i];
		pipeline_decode[i].op_a  = forward(fetch_entry[i].instr[25:21], reg_rdata[2*i],
			pipeline_exec, pipeline_wb);
		pipeline_decode[i].op_b  = use_imm[i] ? imm[i] : forward(fetch_entry[i].instr[20:16],
			reg_rdata[2*i+1], pipeline_exec, pipeline_wb);
		pipeline_decode[i].shamt = fetch_entry[i].instr[10:6];
	end
end

endmodule

// File: src/hilo_unit.sv
`timescale 1ns/1ps

module hilo_unit import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  hilo_req_t wb_req,
	output uint64_t   hilo
);

uint64_t hilo_q;

always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		hilo_q <= '0;
	end else if (wb_req.we) begin
		hilo_q <= wb_req.wdata;
	end
end

// bypass the writeback value so EX reads it this cycle
assign hilo = wb_req.we ? wb_req.wdata : hilo_q;

endmodule

// File: src/instr_exec.sv
`timescale 1ns/1ps

module instr_exec import cpu_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  pipeline_decode_t data,
	input  uint64_t          hilo,
	output pipeline_exec_t   result,
	output logic             stall_req
);

logic    mul_done;
uint64_t mul_prod;

// first cycle of multu computes, second cycle hands the product on
assign stall_req = data.valid && data.op == OP_MULTU && ~mul_done;

always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n)
		mul_done <= 1'b0;
	else
		mul_done <= stall_req;
end

always_ff @(posedge clk) begin
	if (stall_req)
		mul_prod <= {32'b0, data.op_a} * {32'b0, data.op_b};
end

always_comb begin
	result       = '0;
	result.valid = data.valid;
	result.pc    = data.pc;
	result.rd    = data.rd;
	case (data.op)
		OP_ADDU:  result.wdata = data.op_a + data.op_b;
		OP_SUBU:  result.wdata = data.op_a - data.op_b;
		OP_AND:   result.wdata = data.op_a & data.op_b;
		OP_OR:    result.wdata = data.op_a | data.op_b;
		OP_XOR:   result.wdata = data.op_a ^ data.op_b;
		OP_NOR:   result.wdata = ~(data.op_a | data.op_b);
		OP_SLTU:  result.wdata = {31'b0, data.op_a < data.op_b};
		OP_SLL:   result.wdata = data.op_b << data.shamt;
		OP_LUI:   result.wdata = {data.op_b[15:0], 16'b0};
		OP_MFHI:  result.wdata = hilo[63:32];
		OP_MFLO:  result.wdata = hilo[31:0];
		OP_MULTU: begin
			result.hiloreq.we    = mul_done;
			result.hiloreq.wdata = mul_prod;
		end
		default: ;
	endcase
end

endmodule

// File: src/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch import cpu_pkg::*; #(
	parameter virt_t RESET_PC         = 32'hbfc0_0000,
	parameter int    INSTR_FIFO_DEPTH = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	output ibus_req_t          ibus_req,
	input  ibus_resp_t         ibus_resp,
	input  logic [1:0]         issue_num,
	output fetch_entry_t [1:0] fetch_entry
);

localparam int PTR_W = $clog2(INSTR_FIFO_DEPTH);

virt_t            pc;
logic             running;
logic             accept;
logic [PTR_W-1:0] head, tail;
logic [PTR_W:0]   count;
virt_t            q_pc[INSTR_FIFO_DEPTH];
uint32_t          q_instr[INSTR_FIFO_DEPTH];

// room for a full word pair after this cycle's pop
assign ibus_req.read    = running &&
	(int'(count) - int'(issue_num) + 2 <= INSTR_FIFO_DEPTH);
assign ibus_req.address = pc;
assign accept           = ibus_req.read && ~ibus_resp.stall;

always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		running <= 1'b0;
		pc      <= RESET_PC;
		head    <= '0;
		tail    <= '0;
		count   <= '0;
	end else begin
		running <= 1'b1;
		head    <= head + PTR_W'(issue_num);
		count   <= count + (PTR_W+1)'(accept ? 2 : 0) - (PTR_W+1)'(issue_num);
		if (accept) begin
			pc   <= pc + 32'd8;
			tail <= tail + PTR_W'(2);
		end
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		q_pc[tail]               <= pc;
		q_instr[tail]            <= ibus_resp.rddata[31:0];
		q_pc[tail + PTR_W'(1)]    <= pc + 32'd4;
		q_instr[tail + PTR_W'(1)] <= ibus_resp.rddata[63:32];
	end
end

for (genvar i = 0; i < 2; i++) begin : gen_entry
	logic [PTR_W-1:0] idx;
	assign idx                  = head + PTR_W'(i);
	assign fetch_entry[i].valid = count > (PTR_W+1)'(i);
	assign fetch_entry[i].pc    = q_pc[idx];
	assign fetch_entry[i].instr = q_instr[idx];
end

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type T = logic [31:0]
) (
	input  logic clk,
	input  logic rst_n,
	input  logic stall,
	input  logic stall_next,
	input  T     d,
	output T     q
);

// stalled stage with a moving successor emits a bubble
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		q <= '0;
	end else if (stall && ~stall_next) begin
		q <= '0;
	end else if (~stall) begin
		q <= d;
	end
end

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile #(
	parameter int REG_NUM     = 32,
	parameter int DATA_WIDTH  = 32,
	parameter int WRITE_PORTS = 2,
	parameter int READ_PORTS  = 4,
	parameter bit ZERO_KEEP   = 1'b1
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [WRITE_PORTS-1:0]                      we,
	input  logic [WRITE_PORTS-1:0][$clog2(REG_NUM)-1:0] waddr,
	input  logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]      wdata,
	input  logic [READ_PORTS-1:0][$clog2(REG_NUM)-1:0]  raddr,
	output logic [READ_PORTS-1:0][DATA_WIDTH-1:0]       rdata
);

logic [REG_NUM-1:0][DATA_WIDTH-1:0] regs;

// later port overrides earlier one on the same address
always_ff @(posedge clk or negedge rst_n) begin
	if (~rst_n) begin
		regs <= '0;
	end else begin
		for (int i = 0; i < WRITE_PORTS; i++) begin
			if (we[i] && !(ZERO_KEEP && waddr[i] == '0))
				regs[waddr[i]] <= wdata[i];
		end
	end
end

for (genvar i = 0; i < READ_PORTS; i++) begin : gen_read
	assign rdata[i] = (ZERO_KEEP && raddr[i] == '0) ? '0 : regs[raddr[i]];
end

endmodule
